//--- source/ipod_config.svh
`ifndef IPOD_CONFIG_SVH
`define IPOD_CONFIG_SVH

// ==================================================
// Bus and datapath widths
// ==================================================
`define IPOD_ADDR_W       23
`define IPOD_DATA_W       32
`define IPOD_SAMPLE_W     8
`define IPOD_DIV_W        16
`define IPOD_DIGITS       6

// Sample-tick divider, in 50 MHz cycles
`define IPOD_DIV_DEFAULT  16'd2268
`define IPOD_DIV_MIN      16'd268
`define IPOD_DIV_MAX      16'd20268
`define IPOD_SPEED_STEP   16'd100

// Last 32-bit word of the flash
`define IPOD_FLASH_LAST   23'h1FFFFF

// PS/2 scan codes for keys E, D, F and B
`define IPOD_SCAN_PLAY    8'h24
`define IPOD_SCAN_PAUSE   8'h23
`define IPOD_SCAN_FWD     8'h2B
`define IPOD_SCAN_REV     8'h32

`endif

//--- source/ipod_pkg.sv
`include "ipod_config.svh"

package ipod_pkg;

  // Playback controller states
  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT_DATA,
    EMIT_HIGH,
    WAIT_TICK,
    EMIT_LOW
  } player_state_e;

  // Keyboard commands, encoded as their scan codes
  typedef enum logic [7:0] {
    OP_PLAY  = `IPOD_SCAN_PLAY,
    OP_PAUSE = `IPOD_SCAN_PAUSE,
    OP_FWD   = `IPOD_SCAN_FWD,
    OP_REV   = `IPOD_SCAN_REV
  } kbd_op_e;

  // ==================================================
  // Port bundles
  // ==================================================
  typedef struct packed {
    logic                      read;
    logic [`IPOD_ADDR_W-1:0]   address;
  } flash_req_t;

  typedef struct packed {
    logic                      waitrequest;
    logic                      readdatavalid;
    logic [`IPOD_DATA_W-1:0]   readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic                      valid;
    logic [7:0]                code;
  } kbd_in_t;

  // Key levels, high while pressed
  typedef struct packed {
    logic                      up;
    logic                      down;
    logic                      reset;
  } speed_keys_t;

  typedef struct packed {
    logic                             valid;
    logic signed [`IPOD_SAMPLE_W-1:0] sample;
  } audio_out_t;

  // Active-low gfedcba, digit 0 is the least significant
  typedef struct packed {
    logic [`IPOD_DIGITS-1:0][6:0] digit;
  } seg_digits_t;

endpackage

//--- source/player_ctrl.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module player_ctrl
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     tick,
  input  logic                     play,
  input  logic [`IPOD_ADDR_W-1:0]  address,
  input  flash_rsp_t               flash_rsp,
  output flash_req_t               flash_req,
  output logic                     step,
  output audio_out_t               audio
);

  player_state_e            state;
  logic [`IPOD_DATA_W-1:0]  word;

  // ==================================================
  // State sequencing
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      state <= IDLE;
    else
      case (state)
        IDLE:      if (tick && play) state <= REQ;
        // Held here until the flash accepts the read
        REQ:       if (!flash_rsp.waitrequest) state <= WAIT_DATA;
        WAIT_DATA: if (flash_rsp.readdatavalid) state <= EMIT_HIGH;
        EMIT_HIGH: state <= WAIT_TICK;
        WAIT_TICK: if (tick && play) state <= EMIT_LOW;
        EMIT_LOW:  state <= IDLE;
        default:   state <= IDLE;
      endcase
  end

  // Word buffer for both samples
  always_ff @(posedge CLK_50M)
  begin
    if (state == WAIT_DATA && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  // ==================================================
  // Outputs decoded from the state
  // ==================================================
  // Address only moves on step, so it is stable during REQ
  assign flash_req.read    = (state == REQ);
  assign flash_req.address = address;

  assign step = (state == EMIT_LOW);

  assign audio.valid  = (state == EMIT_HIGH) || (state == EMIT_LOW);
  // Byte 3 first, byte 1 after the next tick
  assign audio.sample = (state == EMIT_LOW) ? word[15:8] : word[31:24];

endmodule

//--- source/addr_counter.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module addr_counter
(
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  logic                     step,
  input  logic                     forward,
  output logic [`IPOD_ADDR_W-1:0]  address
);

  localparam logic [`IPOD_ADDR_W-1:0] LAST = `IPOD_FLASH_LAST;

  // Word pointer, wraps at either end of the flash
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      address <= '0;
    else if (step)
    begin
      if (forward)
        address <= (address == LAST) ? '0 : address + 1'b1;
      else
        address <= (address == '0) ? LAST : address - 1'b1;
    end
  end

endmodule

//--- source/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder
  import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    rst,
  input  kbd_in_t kbd,
  output logic    play,
  output logic    forward
);

  // Scan code strobes become play and direction levels
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      play    <= 1'b0;
      forward <= 1'b1;
    end
    else if (kbd.valid)
    begin
      case (kbd.code)
        OP_PLAY:  play    <= 1'b1;
        OP_PAUSE: play    <= 1'b0;
        OP_FWD:   forward <= 1'b1;
        OP_REV:   forward <= 1'b0;
        // Any other key is ignored
        default:  ;
      endcase
    end
  end

endmodule

//--- source/sample_rate_gen.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module sample_rate_gen
  import ipod_pkg::*;
(
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  speed_keys_t             speed_keys,
  output logic                    tick,
  output logic [`IPOD_DIV_W-1:0]  divider
);

  localparam logic [`IPOD_DIV_W-1:0] DIV_DEFAULT = `IPOD_DIV_DEFAULT;
  localparam logic [`IPOD_DIV_W-1:0] DIV_MIN     = `IPOD_DIV_MIN;
  localparam logic [`IPOD_DIV_W-1:0] DIV_MAX     = `IPOD_DIV_MAX;
  localparam logic [`IPOD_DIV_W-1:0] STEP        = `IPOD_SPEED_STEP;

  speed_keys_t             meta, sync, last;
  speed_keys_t             rise;
  logic [`IPOD_DIV_W-1:0]  div_next;
  logic [`IPOD_DIV_W-1:0]  count;

  // ==================================================
  // Key synchronizers and edge detect
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      meta <= '0;
      sync <= '0;
      last <= '0;
    end
    else
    begin
      meta <= speed_keys;
      sync <= meta;
      last <= sync;
    end
  end

  assign rise = sync & ~last;

  // Up means faster playback, so a shorter period
  always_comb
  begin
    div_next = divider;
    if (rise.reset)
      div_next = DIV_DEFAULT;
    else if (rise.up && divider >= DIV_MIN + STEP)
      div_next = divider - STEP;
    else if (rise.down && divider <= DIV_MAX - STEP)
      div_next = divider + STEP;
  end

  // ==================================================
  // Divider register and tick counter
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      divider <= DIV_DEFAULT;
    else
      divider <= div_next;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst || div_next != divider)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count == divider - 1'b1)
    begin
      count <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

//--- source/hex_display.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module hex_display
  import ipod_pkg::*;
(
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic [`IPOD_DIV_W-1:0]  divider,
  output seg_digits_t             hex
);

  localparam int NIBBLES_W = 4 * `IPOD_DIGITS;

  logic [NIBBLES_W-1:0] padded;

  // Active-low segments in gfedcba order
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'hA: seg7 = 7'h08;
      4'hB: seg7 = 7'h03;
      4'hC: seg7 = 7'h46;
      4'hD: seg7 = 7'h21;
      4'hE: seg7 = 7'h06;
      default: seg7 = 7'h0E;
    endcase
  endfunction

  // Upper digits always read 0
  assign padded = {{(NIBBLES_W - `IPOD_DIV_W){1'b0}}, divider};

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      hex <= '1;
    else
      for (int i = 0; i < `IPOD_DIGITS; i++)
        hex.digit[i] <= seg7(padded[4*i +: 4]);
  end

endmodule

//--- source/ipod_player.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module ipod_player
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  kbd_in_t     kbd,
  input  speed_keys_t speed_keys,
  input  flash_rsp_t  flash_rsp,
  output flash_req_t  flash_req,
  output audio_out_t  audio,
  output seg_digits_t hex
);

  logic                     play;
  logic                     forward;
  logic                     tick;
  logic                     step;
  logic [`IPOD_ADDR_W-1:0]  address;
  logic [`IPOD_DIV_W-1:0]   divider;

  // ==================================================
  // Playback path
  // ==================================================
  player_ctrl u_player_ctrl (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .tick      (tick),
    .play      (play),
    .address   (address),
    .flash_rsp (flash_rsp),
    .flash_req (flash_req),
    .step      (step),
    .audio     (audio)
  );

  addr_counter u_addr_counter (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .step    (step),
    .forward (forward),
    .address (address)
  );

  // ==================================================
  // User controls and display
  // ==================================================
  cmd_decoder u_cmd_decoder (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .kbd     (kbd),
    .play    (play),
    .forward (forward)
  );

  sample_rate_gen u_sample_rate_gen (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .speed_keys (speed_keys),
    .tick       (tick),
    .divider    (divider)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .divider (divider),
    .hex     (hex)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
  output logic CLK_50M,
  output logic rst
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Reset held for 16 clock cycles
  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge CLK_50M);
    rst <= 1'b0;
  end

endmodule

//--- sim/tb_flash_model.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module tb_flash_model
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst,
  input  flash_req_t flash_req,
  input  logic       rnd_wait,
  input  logic [1:0] rnd_lat,
  output flash_rsp_t flash_rsp
);

  logic                     busy;
  logic [2:0]               count;
  logic [`IPOD_ADDR_W-1:0]  addr;

  // Byte 3 and byte 1 carry the address, bytes 2 and 0 are filler
  function automatic logic [31:0] word_at(input logic [`IPOD_ADDR_W-1:0] a);
    return {a[7:0] ^ 8'hA5, ~a[7:0], a[15:8], a[22:16] ^ 7'h55, 1'b1};
  endfunction

  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      flash_rsp.waitrequest   <= 1'b0;
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.readdata      <= '0;
      busy                    <= 1'b0;
      count                   <= '0;
      addr                    <= '0;
    end
    else
    begin
      flash_rsp.readdatavalid <= 1'b0;
      flash_rsp.waitrequest   <= rnd_wait;
      if (busy)
      begin
        if (count == 3'd1)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.readdata      <= word_at(addr);
          busy                    <= 1'b0;
        end
        else
          count <= count - 1'b1;
      end
      // Request accepted, latency of 1 to 4 cycles
      else if (flash_req.read && !flash_rsp.waitrequest)
      begin
        busy  <= 1'b1;
        count <= {1'b0, rnd_lat} + 3'd1;
        addr  <= flash_req.address;
      end
    end
  end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module tb_checker
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst,
  input  kbd_in_t     kbd,
  input  flash_req_t  flash_req,
  input  flash_rsp_t  flash_rsp,
  input  audio_out_t  audio,
  input  seg_digits_t hex,
  input  logic [15:0] exp_div,
  input  logic        row_done,
  input  int          row_idx,
  output int          samples_seen,
  output int          errors,
  output logic        hex_match
);

  // Standard active-low gfedcba patterns
  localparam logic [6:0] SEGS [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
    7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  logic [`IPOD_ADDR_W-1:0]     exp_addr;
  logic                        dir_fwd;
  logic                        high_next;
  logic                        started;
  logic                        accepted_d;
  logic                        rdv_d;
  logic [7:0]                  exp_sample;
  logic [4*`IPOD_DIGITS-1:0]   exp_nibbles;
  seg_digits_t                 exp_hex;
  int                          row_err_base;

  // Six nibbles, the top two always zero
  assign exp_nibbles = {8'h00, exp_div};

  always_comb
  begin
    for (int i = 0; i < `IPOD_DIGITS; i++)
      exp_hex.digit[i] = SEGS[exp_nibbles[4*i +: 4]];
  end

  assign hex_match  = (hex == exp_hex);
  assign exp_sample = high_next ? (exp_addr[7:0] ^ 8'hA5) : exp_addr[15:8];

  // ==================================================
  // Sample, request and command tracking
  // ==================================================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      exp_addr     <= '0;
      dir_fwd      <= 1'b1;
      high_next    <= 1'b1;
      started      <= 1'b0;
      accepted_d   <= 1'b0;
      rdv_d        <= 1'b0;
      samples_seen <= 0;
      errors       <= 0;
      row_err_base <= 0;
    end
    else
    begin
      if (kbd.valid && kbd.code == `IPOD_SCAN_PLAY)
        started <= 1'b1;
      if (kbd.valid && kbd.code == `IPOD_SCAN_FWD)
        dir_fwd <= 1'b1;
      if (kbd.valid && kbd.code == `IPOD_SCAN_REV)
        dir_fwd <= 1'b0;

      accepted_d <= flash_req.read && !flash_rsp.waitrequest;
      rdv_d      <= flash_rsp.readdatavalid;

      if (flash_req.read && !flash_rsp.waitrequest)
      begin
        if (!started || flash_req.address != exp_addr)
        begin
          $display("CHECK FAILED at %0t: flash read of %h, expected %h (started %0b)",
                   $time, flash_req.address, exp_addr, started);
          errors <= errors + 1;
        end
      end

      // Read must drop in the cycle after acceptance
      if (accepted_d && flash_req.read)
      begin
        $display("CHECK FAILED at %0t: flash read still high after it was accepted",
                 $time);
        errors <= errors + 1;
      end

      if (audio.valid)
      begin
        samples_seen <= samples_seen + 1;
        if (!started || audio.sample != exp_sample)
        begin
          $display("CHECK FAILED at %0t: sample %h, expected %h from word %h",
                   $time, audio.sample, exp_sample, exp_addr);
          errors <= errors + 1;
        end
        if (high_next && !rdv_d)
        begin
          $display("CHECK FAILED at %0t: high sample %h not one cycle after readdatavalid",
                   $time, audio.sample);
          errors <= errors + 1;
        end
        high_next <= ~high_next;
        // Word done after the low sample
        if (!high_next)
        begin
          if (dir_fwd)
            exp_addr <= (exp_addr == `IPOD_FLASH_LAST) ? '0 : exp_addr + 1'b1;
          else
            exp_addr <= (exp_addr == '0) ? `IPOD_FLASH_LAST : exp_addr - 1'b1;
        end
      end

      if (row_done)
      begin
        if (!hex_match)
        begin
          $display("CHECK FAILED at %0t: hex %h does not show divider %h",
                   $time, hex, exp_div);
          errors <= errors + 1;
        end
        $display("Row %0d finished: %0d samples so far, %0d new errors",
                 row_idx, samples_seen, errors - row_err_base + (hex_match ? 0 : 1));
        row_err_base <= errors + (hex_match ? 0 : 1);
      end
    end
  end

endmodule

//--- sim/tb_ipod_player.sv
`timescale 1ns/100ps
`include "ipod_config.svh"

module tb_ipod_player
  import ipod_pkg::*;
;

  typedef struct packed {
    logic [7:0]  code;
    logic [2:0]  key;
    int          presses;
    int          samples;
    logic [15:0] exp_div;
  } row_t;

  localparam int N_ROWS = 17;
  localparam int QUIET  = `IPOD_DIV_MAX + 20;

  // Key masks follow speed_keys_t {up, down, reset}
  localparam row_t ROWS [N_ROWS] = '{
    '{8'h00,             3'b000,   0, 0, 16'd2268},
    '{`IPOD_SCAN_REV,    3'b000,   0, 0, 16'd2268},
    '{`IPOD_SCAN_PLAY,   3'b000,   0, 6, 16'd2268},
    '{`IPOD_SCAN_PAUSE,  3'b000,   0, 0, 16'd2268},
    '{`IPOD_SCAN_FWD,    3'b000,   0, 0, 16'd2268},
    '{`IPOD_SCAN_PLAY,   3'b000,   0, 6, 16'd2268},
    '{`IPOD_SCAN_PAUSE,  3'b000,   0, 0, 16'd2268},
    '{8'h1C,             3'b000,   0, 0, 16'd2268},
    '{`IPOD_SCAN_PLAY,   3'b000,   0, 3, 16'd2268},
    '{`IPOD_SCAN_PAUSE,  3'b000,   0, 0, 16'd2268},
    '{8'h00,             3'b100,   3, 0, 16'd1968},
    '{8'h00,             3'b010,   5, 0, 16'd2468},
    '{8'h00,             3'b100,  25, 0, 16'd268},
    '{8'h00,             3'b001,   1, 0, 16'd2268},
    '{8'h00,             3'b010, 200, 0, 16'd20268},
    '{8'h00,             3'b001,   1, 0, 16'd2268},
    '{`IPOD_SCAN_PLAY,   3'b000,   0, 4, 16'd2268}
  };

  logic        CLK_50M;
  logic        rst;
  kbd_in_t     kbd;
  speed_keys_t speed_keys;
  flash_rsp_t  flash_rsp;
  flash_req_t  flash_req;
  audio_out_t  audio;
  seg_digits_t hex;
  logic [15:0] exp_div;
  logic        row_done;
  int          row_idx;
  int          samples_seen;
  int          errors;
  logic        hex_match;
  logic [15:0] lfsr;
  logic        rnd_wait;
  logic [1:0]  rnd_lat;
  int          cycles;
  int          limit;

  tb_clock_gen u_clock (.CLK_50M(CLK_50M), .rst(rst));

  ipod_player UUT (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .kbd        (kbd),
    .speed_keys (speed_keys),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .audio      (audio),
    .hex        (hex)
  );

  tb_flash_model u_flash (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .flash_req (flash_req),
    .rnd_wait  (rnd_wait),
    .rnd_lat   (rnd_lat),
    .flash_rsp (flash_rsp)
  );

  tb_checker u_checker (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .kbd          (kbd),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .audio        (audio),
    .hex          (hex),
    .exp_div      (exp_div),
    .row_done     (row_done),
    .row_idx      (row_idx),
    .samples_seen (samples_seen),
    .errors       (errors),
    .hex_match    (hex_match)
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int cycle_budget();
    int total;
    total = 1000;
    for (int i = 0; i < N_ROWS; i++)
      total += (ROWS[i].samples + 2) * QUIET + ROWS[i].presses * 20 + 100;
    return total;
  endfunction

  // One new bit per LFSR step
  always @(negedge CLK_50M)
  begin
    lfsr       = lfsr_next(lfsr);
    rnd_wait   = lfsr[0];
    lfsr       = lfsr_next(lfsr);
    rnd_lat[0] = lfsr[0];
    lfsr       = lfsr_next(lfsr);
    rnd_lat[1] = lfsr[0];
  end

  // ==================================================
  // Timeout
  // ==================================================
  always @(posedge CLK_50M)
  begin
    cycles++;
    if (limit > 0 && cycles >= limit)
    begin
      $display("Timeout: run exceeded %0d cycles at row %0d", limit, row_idx);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic send_code(input logic [7:0] code);
    @(negedge CLK_50M);
    kbd = '{valid: 1'b1, code: code};
    @(negedge CLK_50M);
    kbd = '0;
  endtask

  task automatic press_key(input logic [2:0] mask, input int n);
    repeat (n)
    begin
      @(negedge CLK_50M);
      speed_keys = mask;
      repeat (4) @(negedge CLK_50M);
      speed_keys = '0;
      repeat (4) @(negedge CLK_50M);
    end
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = samples_seen + n;
    while (samples_seen < target)
      @(posedge CLK_50M);
  endtask

  // Quiet means a full slowest tick period with no sample
  task automatic wait_quiet();
    int quiet;
    int last;
    quiet = 0;
    last  = samples_seen;
    while (quiet < QUIET)
    begin
      @(posedge CLK_50M);
      if (samples_seen != last)
      begin
        last  = samples_seen;
        quiet = 0;
      end
      else
        quiet++;
    end
  endtask

  task automatic wait_hex_settle();
    int stable;
    int tries;
    stable = 0;
    tries  = 0;
    while (stable < 8 && tries < 64)
    begin
      @(posedge CLK_50M);
      stable = hex_match ? stable + 1 : 0;
      tries++;
    end
  endtask

  task automatic run_row(input int r);
    row_idx = r;
    exp_div = ROWS[r].exp_div;
    if (ROWS[r].code != 8'h00)
      send_code(ROWS[r].code);
    if (ROWS[r].key != 3'b000)
      press_key(ROWS[r].key, ROWS[r].presses);
    else if (ROWS[r].samples > 0)
      wait_samples(ROWS[r].samples);
    else
      wait_quiet();
    wait_hex_settle();
    @(negedge CLK_50M);
    row_done = 1'b1;
    @(negedge CLK_50M);
    row_done = 1'b0;
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial
  begin
    kbd        = '0;
    speed_keys = '0;
    exp_div    = `IPOD_DIV_DEFAULT;
    row_done   = 1'b0;
    row_idx    = 0;
    lfsr       = 16'd3;
    rnd_wait   = 1'b0;
    rnd_lat    = 2'd0;
    cycles     = 0;
    limit      = cycle_budget();
    @(negedge rst);
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    repeat (4) @(posedge CLK_50M);
    $display("Rows run: %0d, samples seen: %0d, errors: %0d", N_ROWS, samples_seen, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/ipod_pkg.sv
source/player_ctrl.sv
source/addr_counter.sv
source/cmd_decoder.sv
source/sample_rate_gen.sv
source/hex_display.sv
source/ipod_player.sv
sim/tb_clock_gen.sv
sim/tb_flash_model.sv
sim/tb_checker.sv
sim/tb_ipod_player.sv

//--- Makefile
SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN     := obj_dir/Vtb_ipod_player

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SOURCES)
	verilator --binary --timing --top-module tb_ipod_player -f files.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
